/* ibuf_conf_pkg.sv */
package ibuf_conf_pkg;

  // fetch side
  localparam int VADDR_W    = 32;
  localparam int LINE_W     = 128;
  localparam int LINE_WORDS = 4;    // 32-bit words per fetch line
  localparam int WORD_POS_W = 2;

  // line queue
  localparam int INST_BUF_SIZE = 4;
  localparam int BUF_PTR_W     = 2;

  // dispatch group limits
  localparam int DISP_SIZE       = 3;
  localparam int ARITH_DISP_SIZE = 2;
  localparam int MEM_DISP_SIZE   = 1;    // loads and stores share this

  typedef logic [VADDR_W-1:0]    vaddr_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [WORD_POS_W-1:0] word_pos_t;
  typedef logic [BUF_PTR_W-1:0]  buf_ptr_t;

endpackage

/* ibuf_isa_pkg.sv */
package ibuf_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32I major opcodes, inst[6:0]
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // anything not a load or store counts as arith
  typedef enum logic [1:0] {
    CAT_ARITH = 2'b00,
    CAT_LD    = 2'b01,
    CAT_ST    = 2'b10
  } inst_cat_t;

endpackage

/* ibuf_line_queue.sv */
module ibuf_line_queue
  import ibuf_conf_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_reset_n,

  input  logic   i_push,
  input  vaddr_t i_push_pc,
  input  line_t  i_push_line,
  output logic   o_not_full,

  input  logic   i_retire,
  output logic   o_head_valid,
  output vaddr_t o_head_pc,
  output line_t  o_head_line
);

  logic [INST_BUF_SIZE-1:0] r_vld;
  vaddr_t                   r_pc   [INST_BUF_SIZE];
  line_t                    r_line [INST_BUF_SIZE];

  buf_ptr_t r_in_ptr;
  buf_ptr_t r_out_ptr;
  buf_ptr_t w_in_ptr_next;
  buf_ptr_t w_out_ptr_next;

  assign w_in_ptr_next  = (r_in_ptr == buf_ptr_t'(INST_BUF_SIZE - 1)) ? '0 : r_in_ptr + 1'b1;
  assign w_out_ptr_next = (r_out_ptr == buf_ptr_t'(INST_BUF_SIZE - 1)) ? '0 : r_out_ptr + 1'b1;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
    end else begin
      if (i_push) begin
        r_in_ptr <= w_in_ptr_next;
      end
      if (i_retire) begin
        r_out_ptr <= w_out_ptr_next;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vld <= '0;
    end else begin
      for (int idx = 0; idx < INST_BUF_SIZE; idx++) begin
        if (i_push && (r_in_ptr == buf_ptr_t'(idx))) begin
          r_vld[idx] <= 1'b1;
        end else if (i_retire && (r_out_ptr == buf_ptr_t'(idx))) begin
          r_vld[idx] <= 1'b0;
        end
      end
    end
  end

  // line payload written at the in-pointer
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_pc[r_in_ptr]   <= i_push_pc;
      r_line[r_in_ptr] <= i_push_line;
    end
  end

  assign o_not_full   = !(&r_vld);
  assign o_head_valid = r_vld[r_out_ptr];
  assign o_head_pc    = r_pc[r_out_ptr];
  assign o_head_line  = r_line[r_out_ptr];

endmodule

/* ibuf_inst_decoder.sv */
module ibuf_inst_decoder
  import ibuf_isa_pkg::*;
(
  input  inst_t     i_inst,
  output inst_cat_t o_cat,
  output logic      o_rd_valid,
  output logic      o_rs1_valid,
  output logic      o_rs2_valid
);

  opcode_t  w_opcode;
  reg_idx_t w_rd_idx;
  logic     w_writes_rd;

  assign w_opcode = i_inst[6:0];
  assign w_rd_idx = i_inst[11:7];

  always_comb begin
    case (w_opcode)
      OPC_LOAD:  o_cat = CAT_LD;
      OPC_STORE: o_cat = CAT_ST;
      default:   o_cat = CAT_ARITH;
    endcase
  end

  // register use per RV32I format
  always_comb begin
    w_writes_rd = 1'b0;
    o_rs1_valid = 1'b0;
    o_rs2_valid = 1'b0;
    case (w_opcode)
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: begin  // I-type
        w_writes_rd = 1'b1;
        o_rs1_valid = 1'b1;
      end
      OPC_OP: begin  // R-type
        w_writes_rd = 1'b1;
        o_rs1_valid = 1'b1;
        o_rs2_valid = 1'b1;
      end
      OPC_STORE, OPC_BRANCH: begin  // S/B-type without rd
        o_rs1_valid = 1'b1;
        o_rs2_valid = 1'b1;
      end
      OPC_LUI, OPC_AUIPC, OPC_JAL: begin  // U/J-type
        w_writes_rd = 1'b1;
      end
      default: begin
        w_writes_rd = 1'b0;  // unknown opcode uses no registers
      end
    endcase
  end

  assign o_rd_valid = w_writes_rd & (w_rd_idx != '0);  // x0 writes are dropped

endmodule

/* ibuf_dispatch_select.sv */
module ibuf_dispatch_select
  import ibuf_conf_pkg::*;
  import ibuf_isa_pkg::*;
(
  input  logic [DISP_SIZE-1:0] i_cand,
  input  inst_cat_t            i_cat [DISP_SIZE],
  output logic [DISP_SIZE-1:0] o_disp_mask
);

  // walk slots in order and stop at the first one over a limit
  always_comb begin
    int   arith_cnt;
    int   mem_cnt;
    logic in_prefix;

    arith_cnt   = 0;
    mem_cnt     = 0;
    in_prefix   = 1'b1;
    o_disp_mask = '0;
    for (int k = 0; k < DISP_SIZE; k++) begin
      if (i_cat[k] == CAT_ARITH) begin
        arith_cnt = arith_cnt + 1;
      end else begin
        mem_cnt = mem_cnt + 1;  // load or store
      end
      if (in_prefix && i_cand[k] &&
          (arith_cnt <= ARITH_DISP_SIZE) && (mem_cnt <= MEM_DISP_SIZE)) begin
        o_disp_mask[k] = 1'b1;
      end else begin
        in_prefix = 1'b0;  // later slots stay out
      end
    end
  end

endmodule

/* ibuf_inst_buffer.sv */
module ibuf_inst_buffer
  import ibuf_conf_pkg::*;
  import ibuf_isa_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,

  // fill side
  input  logic                 i_inst_vld,
  input  vaddr_t               i_inst_pc,
  input  line_t                i_inst_line,
  output logic                 o_inst_rdy,

  // dispatch side
  output logic                 o_disp_group_valid,
  output logic [DISP_SIZE-1:0] o_disp_valid,
  output inst_t                o_disp_inst [DISP_SIZE],
  output vaddr_t               o_disp_pc [DISP_SIZE],
  output inst_cat_t            o_disp_cat [DISP_SIZE],
  output logic [DISP_SIZE-1:0] o_disp_rd_valid,
  output logic [DISP_SIZE-1:0] o_disp_rs1_valid,
  output logic [DISP_SIZE-1:0] o_disp_rs2_valid,
  input  logic                 i_disp_ready
);

  logic   w_push;
  logic   w_not_full;
  logic   w_retire;
  logic   w_fire;
  logic   w_head_valid;
  vaddr_t w_head_pc;
  line_t  w_head_line;

  word_pos_t             r_head_start;       // first unissued word of head line
  logic [WORD_POS_W:0]   w_group_size;
  logic [WORD_POS_W:0]   w_next_start;

  inst_t                 w_inst [DISP_SIZE];
  inst_cat_t             w_cat [DISP_SIZE];
  logic [DISP_SIZE-1:0]  w_rd_valid;
  logic [DISP_SIZE-1:0]  w_rs1_valid;
  logic [DISP_SIZE-1:0]  w_rs2_valid;
  logic [DISP_SIZE-1:0]  w_cand;
  logic [DISP_SIZE-1:0]  w_disp_mask;

  assign w_push     = i_inst_vld & w_not_full;
  assign o_inst_rdy = w_not_full;

  ibuf_line_queue u_line_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_push       (w_push),
    .i_push_pc    (i_inst_pc),
    .i_push_line  (i_inst_line),
    .o_not_full   (w_not_full),
    .i_retire     (w_retire),
    .o_head_valid (w_head_valid),
    .o_head_pc    (w_head_pc),
    .o_head_line  (w_head_line)
  );

  generate
    for (genvar k = 0; k < DISP_SIZE; k++) begin : slot_loop
      logic [WORD_POS_W:0] w_pos;

      assign w_pos     = {1'b0, r_head_start} + (WORD_POS_W + 1)'(k);
      assign w_cand[k] = w_head_valid & (w_pos < LINE_WORDS);  // no crossing into next line
      assign w_inst[k] = w_head_line[w_pos[WORD_POS_W-1:0] * $bits(inst_t) +: $bits(inst_t)];

      ibuf_inst_decoder u_decoder (
        .i_inst      (w_inst[k]),
        .o_cat       (w_cat[k]),
        .o_rd_valid  (w_rd_valid[k]),
        .o_rs1_valid (w_rs1_valid[k]),
        .o_rs2_valid (w_rs2_valid[k])
      );

      // unused slots drive zeros
      always_comb begin
        if (w_disp_mask[k]) begin
          o_disp_inst[k]      = w_inst[k];
          o_disp_pc[k]        = w_head_pc + vaddr_t'({w_pos, 2'b00});
          o_disp_cat[k]       = w_cat[k];
          o_disp_rd_valid[k]  = w_rd_valid[k];
          o_disp_rs1_valid[k] = w_rs1_valid[k];
          o_disp_rs2_valid[k] = w_rs2_valid[k];
        end else begin
          o_disp_inst[k]      = '0;
          o_disp_pc[k]        = '0;
          o_disp_cat[k]       = CAT_ARITH;
          o_disp_rd_valid[k]  = 1'b0;
          o_disp_rs1_valid[k] = 1'b0;
          o_disp_rs2_valid[k] = 1'b0;
        end
      end
    end
  endgenerate

  ibuf_dispatch_select u_dispatch_select (
    .i_cand      (w_cand),
    .i_cat       (w_cat),
    .o_disp_mask (w_disp_mask)
  );

  assign o_disp_valid       = w_disp_mask;
  assign o_disp_group_valid = |w_disp_mask;
  assign w_fire             = o_disp_group_valid & i_disp_ready;

  // mask is a prefix, so its popcount is the group size
  always_comb begin
    w_group_size = '0;
    for (int k = 0; k < DISP_SIZE; k++) begin
      w_group_size = w_group_size + (WORD_POS_W + 1)'(w_disp_mask[k]);
    end
  end

  assign w_next_start = {1'b0, r_head_start} + w_group_size;
  assign w_retire     = w_fire & (w_next_start >= LINE_WORDS);  // head line fully issued

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head_start <= '0;
    end else if (w_retire) begin
      r_head_start <= '0;
    end else if (w_fire) begin
      r_head_start <= w_next_start[WORD_POS_W-1:0];
    end
  end

endmodule

/* ibuf_tb_clk_gen.sv */
module ibuf_tb_clk_gen (
  output logic o_clk
);

  localparam int HALF_PERIOD = 4;  // 8 time unit period

  initial begin
    o_clk = 1'b0;
    forever begin
      #HALF_PERIOD o_clk = ~o_clk;
    end
  end

endmodule

/* ibuf_properties.sv */
module ibuf_properties
  import ibuf_conf_pkg::*;
  import ibuf_isa_pkg::*;
(
  input logic                 i_clk,
  input logic                 i_reset_n,
  input logic                 i_push,
  input logic                 i_retire,
  input logic                 i_inst_rdy,
  input logic                 i_disp_ready,
  input logic                 i_disp_group_valid,
  input logic [DISP_SIZE-1:0] i_disp_valid,
  input vaddr_t               i_first_pc,
  input inst_t                i_first_inst
);

  logic [BUF_PTR_W:0] r_lines_held;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_lines_held <= '0;
    end else begin
      r_lines_held <= r_lines_held + i_push - i_retire;
    end
  end

  a_idle_after_reset: assert property (
    @(posedge i_clk) $rose(i_reset_n) |-> !i_disp_group_valid
  ) else $error("dispatch group offered right after reset");

  // x & (x + 1) is zero only for masks of the form 0..01..1
  a_prefix_mask: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    ((i_disp_valid + 1) & i_disp_valid) == 0
  ) else $error("o_disp_valid is not a prefix mask");

  a_hold_when_stalled: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_disp_group_valid && !i_disp_ready) |=>
      ($stable(i_disp_valid) && $stable(i_first_pc) && $stable(i_first_inst))
  ) else $error("dispatch group changed while the consumer stalled");

  a_full_not_ready: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    ((r_lines_held == INST_BUF_SIZE) && !i_retire) |-> !i_inst_rdy
  ) else $error("fill side ready while all four lines are held");

endmodule

bind ibuf_inst_buffer ibuf_properties ibuf_properties_i (
  .i_clk              (i_clk),
  .i_reset_n          (i_reset_n),
  .i_push             (w_push),
  .i_retire           (w_retire),
  .i_inst_rdy         (o_inst_rdy),
  .i_disp_ready       (i_disp_ready),
  .i_disp_group_valid (o_disp_group_valid),
  .i_disp_valid       (o_disp_valid),
  .i_first_pc         (o_disp_pc[0]),
  .i_first_inst       (o_disp_inst[0])
);

/* ibuf_tb.sv */
module ibuf_tb
  import ibuf_conf_pkg::*;
  import ibuf_isa_pkg::*;
();

  localparam int N_ENTRIES = 8;
  localparam int MAX_STALL = 12;
  localparam int WATCHDOG_CYCLES = N_ENTRIES * (LINE_WORDS + MAX_STALL + 4) + 20;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_inst_vld;
  vaddr_t               i_inst_pc;
  line_t                i_inst_line;
  logic                 o_inst_rdy;
  logic                 o_disp_group_valid;
  logic [DISP_SIZE-1:0] o_disp_valid;
  inst_t                o_disp_inst [DISP_SIZE];
  vaddr_t               o_disp_pc [DISP_SIZE];
  inst_cat_t            o_disp_cat [DISP_SIZE];
  logic [DISP_SIZE-1:0] o_disp_rd_valid;
  logic [DISP_SIZE-1:0] o_disp_rs1_valid;
  logic [DISP_SIZE-1:0] o_disp_rs2_valid;
  logic                 i_disp_ready;

  // stimulus table
  vaddr_t tab_pc [N_ENTRIES];
  line_t  tab_line [N_ENTRIES];
  int     tab_stall [N_ENTRIES];  // consumer idle cycles before this line drains

  // reference model state
  int          exp_entry_q [$];
  int          exp_start_q [$];
  int          pushed_lines;
  int          retired_lines;
  int          lines_held;
  int          group_cnt;
  int          error_cnt;
  logic [31:0] rand_state;

  ibuf_tb_clk_gen clk_gen_i (
    .o_clk (i_clk)
  );

  ibuf_inst_buffer ibuf_inst_buffer_i (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_inst_vld         (i_inst_vld),
    .i_inst_pc          (i_inst_pc),
    .i_inst_line        (i_inst_line),
    .o_inst_rdy         (o_inst_rdy),
    .o_disp_group_valid (o_disp_group_valid),
    .o_disp_valid       (o_disp_valid),
    .o_disp_inst        (o_disp_inst),
    .o_disp_pc          (o_disp_pc),
    .o_disp_cat         (o_disp_cat),
    .o_disp_rd_valid    (o_disp_rd_valid),
    .o_disp_rs1_valid   (o_disp_rs1_valid),
    .o_disp_rs2_valid   (o_disp_rs2_valid),
    .i_disp_ready       (i_disp_ready)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  // register fields land in the same bits for every format
  function automatic inst_t make_inst(opcode_t op, int rd, int rs1, int rs2);
    return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], op};
  endfunction

  function automatic inst_t word_at(int entry, int pos);
    return tab_line[entry][pos*32 +: 32];
  endfunction

  function automatic inst_cat_t expected_cat(inst_t w);
    if (w[6:0] == OPC_LOAD) begin
      return CAT_LD;
    end
    if (w[6:0] == OPC_STORE) begin
      return CAT_ST;
    end
    return CAT_ARITH;
  endfunction

  // {rd, rs1, rs2}
  function automatic logic [2:0] expected_regs(inst_t w);
    logic [2:0] use_bits;
    case (w[6:0])
      OPC_OP:                         use_bits = 3'b111;
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: use_bits = 3'b110;
      OPC_STORE, OPC_BRANCH:          use_bits = 3'b011;
      OPC_LUI, OPC_AUIPC, OPC_JAL:    use_bits = 3'b100;
      default:                        use_bits = 3'b000;
    endcase
    if (w[11:7] == 5'd0) begin
      use_bits[2] = 1'b0;  // x0 never written
    end
    return use_bits;
  endfunction

  function automatic int group_len(int entry, int start);
    int   n;
    int   arith;
    int   mem;
    logic stop;
    n = 0;
    arith = 0;
    mem = 0;
    stop = 1'b0;
    for (int k = 0; k < DISP_SIZE; k++) begin
      if (!stop && (start + k < LINE_WORDS)) begin
        if (expected_cat(word_at(entry, start + k)) == CAT_ARITH) begin
          arith++;
        end else begin
          mem++;
        end
        if ((arith > ARITH_DISP_SIZE) || (mem > MEM_DISP_SIZE)) begin
          stop = 1'b1;
        end else begin
          n++;
        end
      end else begin
        stop = 1'b1;
      end
    end
    return n;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      error_cnt++;
      $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_group(int entry, int start);
    int         n;
    int         pos;
    inst_t      w;
    vaddr_t     pc;
    inst_cat_t  cat;
    logic [2:0] regs;
    n = group_len(entry, start);
    for (int k = 0; k < DISP_SIZE; k++) begin
      pos = start + k;
      w = '0;
      pc = '0;
      cat = CAT_ARITH;
      regs = 3'b000;
      if (k < n) begin
        w = word_at(entry, pos);
        pc = tab_pc[entry] + 4 * pos;
        cat = expected_cat(w);
        regs = expected_regs(w);
      end
      check_value($sformatf("o_disp_valid[%0d]", k), k < n, o_disp_valid[k]);
      check_value($sformatf("o_disp_inst[%0d]", k), w, o_disp_inst[k]);
      check_value($sformatf("o_disp_pc[%0d]", k), pc, o_disp_pc[k]);
      check_value($sformatf("o_disp_cat[%0d]", k), cat, o_disp_cat[k]);
      check_value($sformatf("o_disp_rd_valid[%0d]", k), regs[2], o_disp_rd_valid[k]);
      check_value($sformatf("o_disp_rs1_valid[%0d]", k), regs[1], o_disp_rs1_valid[k]);
      check_value($sformatf("o_disp_rs2_valid[%0d]", k), regs[0], o_disp_rs2_valid[k]);
    end
  endtask

  task automatic queue_groups(int entry);
    int start;
    start = 0;
    while (start < LINE_WORDS) begin
      exp_entry_q.push_back(entry);
      exp_start_q.push_back(start);
      start = start + group_len(entry, start);
    end
  endtask

  // looks at the cycle ahead of the next rising edge
  task automatic sample_cycle();
    int entry;
    int start;
    check_value("o_inst_rdy", lines_held < INST_BUF_SIZE, o_inst_rdy);
    check_value("o_disp_group_valid", exp_entry_q.size() != 0, o_disp_group_valid);
    if (o_disp_group_valid && (exp_entry_q.size() != 0)) begin
      entry = exp_entry_q[0];
      start = exp_start_q[0];
      compare_group(entry, start);  // checked while stalled too
      if (i_disp_ready) begin
        entry = exp_entry_q.pop_front();
        start = exp_start_q.pop_front();
        group_cnt++;
        if (start + group_len(entry, start) >= LINE_WORDS) begin
          retired_lines++;
          lines_held--;
        end
      end
    end
    if (i_inst_vld && o_inst_rdy) begin
      queue_groups(pushed_lines);
      pushed_lines++;
      lines_held++;
    end
  endtask

  task automatic load_table();
    tab_pc[0] = 32'h0000_1000;
    tab_stall[0] = 12;  // long enough to fill the queue
    tab_line[0] = {make_inst(OPC_AUIPC, 4, 0, 0), make_inst(OPC_LUI, 3, 7, 9),
                   make_inst(OPC_OP_IMM, 2, 1, 0), make_inst(OPC_OP, 1, 2, 3)};
    tab_pc[1] = 32'h0000_1010;
    tab_stall[1] = 0;
    tab_line[1] = {make_inst(OPC_OP, 7, 6, 1), make_inst(OPC_STORE, 4, 2, 6),
                   make_inst(OPC_OP, 6, 5, 5), make_inst(OPC_LOAD, 5, 1, 0)};
    tab_pc[2] = 32'h0000_2000;
    tab_stall[2] = 3;
    tab_line[2] = {make_inst(OPC_BRANCH, 12, 8, 9), make_inst(OPC_LOAD, 9, 2, 0),
                   make_inst(OPC_LOAD, 8, 2, 0), make_inst(OPC_JAL, 0, 3, 5)};
    tab_pc[3] = 32'h8000_0040;
    tab_stall[3] = 0;
    tab_line[3] = {make_inst(OPC_OP_IMM, 13, 12, 0), make_inst(OPC_OP, 12, 10, 11),
                   make_inst(OPC_LOAD, 11, 3, 0), make_inst(OPC_LOAD, 10, 3, 0)};
    tab_pc[4] = 32'h8000_0050;  // waits for the head line to retire
    tab_stall[4] = 2;
    tab_line[4] = {make_inst(OPC_BRANCH, 2, 1, 4), make_inst(OPC_OP_IMM, 0, 0, 0),
                   make_inst(OPC_JALR, 0, 1, 0), make_inst(OPC_STORE, 8, 2, 3)};
    tab_pc[5] = 32'h0001_0000;
    tab_stall[5] = 1;
    tab_line[5] = {make_inst(OPC_JAL, 1, 0, 0), make_inst(OPC_AUIPC, 0, 4, 4),
                   make_inst(OPC_OP, 15, 14, 2), make_inst(OPC_OP_IMM, 14, 1, 0)};
    tab_pc[6] = 32'h0001_0010;
    tab_stall[6] = 0;
    tab_line[6] = {make_inst(OPC_OP, 17, 16, 1), make_inst(OPC_LOAD, 16, 2, 0),
                   make_inst(OPC_STORE, 5, 3, 4), make_inst(OPC_LUI, 0, 31, 31)};
    tab_pc[7] = 32'hffff_fff0;
    tab_stall[7] = 5;
    tab_line[7] = {make_inst(OPC_STORE, 0, 5, 6), make_inst(OPC_JALR, 5, 6, 0),
                   make_inst(OPC_BRANCH, 1, 7, 8), make_inst(OPC_BRANCH, 3, 1, 2)};
  endtask

  task automatic feed_lines();
    for (int e = 0; e < N_ENTRIES; e++) begin
      i_inst_vld  <= 1'b1;
      i_inst_pc   <= tab_pc[e];
      i_inst_line <= tab_line[e];
      @(posedge i_clk);
      while (pushed_lines == e) begin
        @(posedge i_clk);
      end
    end
    i_inst_vld <= 1'b0;
  endtask

  task automatic drain_groups();
    for (int e = 0; e < N_ENTRIES; e++) begin
      i_disp_ready <= 1'b0;
      repeat (tab_stall[e]) @(posedge i_clk);
      while (retired_lines == e) begin
        i_disp_ready <= (next_rand() & 32'd3) != 32'd0;  // stall about one cycle in four
        @(posedge i_clk);
      end
    end
    i_disp_ready <= 1'b0;
  endtask

  always @(negedge i_clk) begin
    if (i_reset_n) begin
      sample_cycle();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Error: run timed out after %0d cycles with %0d errors", WATCHDOG_CYCLES,
             error_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    load_table();
    rand_state    = 32'h36960963;
    pushed_lines  = 0;
    retired_lines = 0;
    lines_held    = 0;
    group_cnt     = 0;
    error_cnt     = 0;
    i_reset_n     = 1'b0;
    i_inst_vld    = 1'b0;
    i_inst_pc     = '0;
    i_inst_line   = '0;
    i_disp_ready  = 1'b0;
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;
    fork
      feed_lines();
      drain_groups();
    join
    @(posedge i_clk);
    $display("Summary: %0d groups checked, %0d errors", group_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* ibuf.f */
ibuf_conf_pkg.sv
ibuf_isa_pkg.sv
ibuf_line_queue.sv
ibuf_inst_decoder.sv
ibuf_dispatch_select.sv
ibuf_inst_buffer.sv
ibuf_tb_clk_gen.sv
ibuf_properties.sv
ibuf_tb.sv
